// File: logic/lsu_defs.svh
/*
  load/store unit parameters
  widths, outstanding-transfer limit and the type / extension codes
*/
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

// datapath widths
`define LSU_XLEN 32 // data and address width
`define LSU_BE_W 4  // one enable per byte lane

// bus transfers in flight
`define LSU_MAX_OUTSTANDING 2
`define LSU_CNT_W 2 // holds 0..2

// data type, code 3 decodes as byte too
`define LSU_TYPE_WORD 2'd0
`define LSU_TYPE_HALF 2'd1
`define LSU_TYPE_BYTE 2'd2

// extension mode, code 3 decodes as sign
`define LSU_EXT_ZERO 2'd0
`define LSU_EXT_SIGN 2'd1
`define LSU_EXT_ONE  2'd2

`endif

// File: logic/lsu_pkg.sv
/*
  load/store unit types
  vector typedefs and the request, bus and write-back structs
*/
`include "lsu_defs.svh"

package lsu_pkg;

  ////////////////////
  // plain vectors
  ////////////////////
  typedef logic [`LSU_XLEN-1:0]  word_t;   // data or address
  typedef logic [`LSU_BE_W-1:0]  be_t;     // byte lane enables
  typedef logic [1:0]            offset_t; // byte within word
  typedef logic [1:0]            dtype_t;  // word / half / byte
  typedef logic [1:0]            ext_t;    // zero / sign / one fill
  typedef logic [`LSU_CNT_W-1:0] cnt_t;    // transfers in flight

  ////////////////////
  // grouped signals
  ////////////////////

  // access as presented by the execute stage
  typedef struct packed {
    logic    we;         // store when set
    dtype_t  dtype;
    ext_t    ext;        // extension for loads
    offset_t reg_offset; // byte offset inside the source register
    word_t   wdata;      // store data, unrotated
    word_t   operand_a;  // base address
    word_t   operand_b;  // increment
    logic    use_incr;   // address is a + b
  } lsu_req_t;

  // request/grant data bus, address phase
  typedef struct packed {
    word_t addr;
    logic  we;
    be_t   be;
    word_t wdata; // already rotated into lanes
  } bus_req_t;

  // captured on acceptance, used when rvalid returns
  typedef struct packed {
    dtype_t  dtype;
    offset_t offset; // byte offset of the access
    ext_t    ext;
    logic    we;     // response belongs to a store
  } wb_ctrl_t;

endpackage

// File: logic/lsu_decode.sv
/*
  load/store decode
  address generation, misalignment check, byte enables and
  store data lane rotation, all combinational
*/
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_decode (
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              req_valid_i,
  input  logic              misaligned_phase_i, // second half of a split access
  output lsu_pkg::bus_req_t bus_o,
  output lsu_pkg::offset_t  offset_o,
  output logic              misaligned_o        // core must replay a second phase
);

  lsu_pkg::word_t   addr;         // effective byte address
  lsu_pkg::offset_t wdata_offset; // lane rotation amount
  lsu_pkg::be_t     be;
  lsu_pkg::word_t   wdata_rot;

  // base only or base plus increment
  assign addr = req_i.use_incr ? (req_i.operand_a + req_i.operand_b) : req_i.operand_a;

  assign offset_o = addr[1:0];

  ////////////////////
  // byte enables
  ////////////////////
  always_comb begin
    case (req_i.dtype)
      `LSU_TYPE_WORD: begin
        if (!misaligned_phase_i) begin // lanes from offset upward
          case (addr[1:0])
            2'b00:   be = 4'b1111;
            2'b01:   be = 4'b1110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000;
          endcase
        end else begin // remaining low lanes of next word
          case (addr[1:0])
            2'b00:   be = 4'b0000; // never split at offset 0
            2'b01:   be = 4'b0001;
            2'b10:   be = 4'b0011;
            default: be = 4'b0111;
          endcase
        end
      end
      `LSU_TYPE_HALF: begin
        if (!misaligned_phase_i) begin
          case (addr[1:0])
            2'b00:   be = 4'b0011;
            2'b01:   be = 4'b0110;
            2'b10:   be = 4'b1100;
            default: be = 4'b1000; // upper byte goes in phase two
          endcase
        end else begin
          be = 4'b0001; // only split at offset 3
        end
      end
      default: begin // byte, codes 2 and 3
        case (addr[1:0])
          2'b00:   be = 4'b0001;
          2'b01:   be = 4'b0010;
          2'b10:   be = 4'b0100;
          default: be = 4'b1000;
        endcase
      end
    endcase
  end

  ////////////////////
  // store data rotation
  ////////////////////

  // register offset lets phase two send the upper part of the register
  assign wdata_offset = addr[1:0] - req_i.reg_offset;

  always_comb begin
    case (wdata_offset) // rotate left by bytes
      2'b00:   wdata_rot = req_i.wdata;
      2'b01:   wdata_rot = {req_i.wdata[23:0], req_i.wdata[31:24]};
      2'b10:   wdata_rot = {req_i.wdata[15:0], req_i.wdata[31:16]};
      default: wdata_rot = {req_i.wdata[7:0], req_i.wdata[31:8]};
    endcase
  end

  ////////////////////
  // split detection
  ////////////////////
  always_comb begin
    misaligned_o = 1'b0;
    if (req_valid_i && !misaligned_phase_i) begin
      if (req_i.dtype == `LSU_TYPE_WORD && addr[1:0] != 2'b00) begin
        misaligned_o = 1'b1; // word crosses a word boundary
      end
      if (req_i.dtype == `LSU_TYPE_HALF && addr[1:0] == 2'b11) begin
        misaligned_o = 1'b1; // half straddles bytes 3 and 4
      end
    end
  end

  // phase two starts at the next word, low lanes enabled
  assign bus_o.addr  = misaligned_phase_i ? {addr[31:2], 2'b00} : addr;
  assign bus_o.we    = req_i.we;
  assign bus_o.be    = be;
  assign bus_o.wdata = wdata_rot;

endmodule

// File: logic/lsu_execute.sv
/*
  load/store bus control
  tracks transfers in flight, gates the bus request, derives
  the stage ready and busy levels and holds write-back control
*/
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_execute (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               req_valid_i,
  input  lsu_pkg::lsu_req_t  req_i,
  input  lsu_pkg::offset_t   offset_i,
  input  lsu_pkg::bus_req_t  bus_i,     // decoded address phase
  output logic               bus_req_o,
  output lsu_pkg::bus_req_t  bus_o,
  input  logic               bus_gnt_i,
  input  logic               bus_rvalid_i,
  output logic               ready_ex_o,
  output logic               ready_wb_o,
  output logic               busy_o,
  output lsu_pkg::wb_ctrl_t  wb_ctrl_o
);

  lsu_pkg::cnt_t cnt_q;       // transfers awaiting rvalid
  lsu_pkg::cnt_t cnt_d;
  logic          accept;      // request and grant in same cycle
  logic          ctrl_update; // execute hands its access to write-back

  ////////////////////
  // bus request
  ////////////////////

  // no room once the limit is reached, rvalid is not looked at here
  assign bus_req_o = req_valid_i && (cnt_q < lsu_pkg::cnt_t'(`LSU_MAX_OUTSTANDING));
  assign bus_o     = bus_i; // held stable by the core until granted
  assign accept    = bus_req_o && bus_gnt_i;

  // something in flight or about to be
  assign busy_o = (cnt_q != '0) || bus_req_o;

  // write-back free when empty, else when its response lands
  assign ready_wb_o = (cnt_q == '0) ? 1'b1 : bus_rvalid_i;

  // execute and write-back advance in lock step
  always_comb begin
    if (!req_valid_i) begin
      ready_ex_o = 1'b1; // nothing to do
    end else if (cnt_q == '0) begin
      ready_ex_o = accept;
    end else if (cnt_q == lsu_pkg::cnt_t'(1)) begin
      ready_ex_o = bus_rvalid_i && accept; // wb slot must drain too
    end else begin
      ready_ex_o = bus_rvalid_i; // full, wait for a response
    end
  end

  assign ctrl_update = ready_ex_o && req_valid_i;

  ////////////////////
  // in-flight counter
  ////////////////////
  always_comb begin
    case ({accept, bus_rvalid_i})
      2'b10:   cnt_d = cnt_q + 1'b1;
      2'b01:   cnt_d = cnt_q - 1'b1;
      default: cnt_d = cnt_q; // idle or one in, one out
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // response decoding info, one entry is enough since ready is lock-stepped
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ctrl_o <= '0;
    end else if (ctrl_update) begin
      wb_ctrl_o.dtype  <= req_i.dtype;
      wb_ctrl_o.offset <= offset_i;
      wb_ctrl_o.ext    <= req_i.ext;
      wb_ctrl_o.we     <= req_i.we;
    end
  end

endmodule

// File: logic/lsu_result.sv
/*
  load result path
  picks the byte or halfword out of the response, joins split
  loads with the stored first half and extends per mode
*/
`timescale 1ns/100ps
`include "lsu_defs.svh"

module lsu_result (
  input  logic              clk,
  input  logic              rst_n,
  input  lsu_pkg::wb_ctrl_t wb_ctrl_i,
  input  logic              rvalid_i,
  input  lsu_pkg::word_t    rdata_i,
  input  logic              misaligned_phase_i, // core in second phase
  input  logic              misaligned_i,       // split just detected
  output lsu_pkg::word_t    rdata_o
);

  lsu_pkg::word_t rdata_q;   // first half or last result
  lsu_pkg::word_t rdata_w;   // word, possibly joined
  lsu_pkg::word_t rdata_h;   // extended halfword
  lsu_pkg::word_t rdata_b;   // extended byte
  lsu_pkg::word_t rdata_ext; // finished value
  logic [15:0]    half_sel;
  logic [7:0]     byte_sel;

  // upper fill bit for a given mode
  function automatic logic fill_bit(input logic sign_bit, input lsu_pkg::ext_t mode);
    case (mode)
      `LSU_EXT_ZERO: fill_bit = 1'b0;
      `LSU_EXT_ONE:  fill_bit = 1'b1;
      default:       fill_bit = sign_bit; // sign, codes 1 and 3
    endcase
  endfunction

  ////////////////////
  // lane selection
  ////////////////////

  // split word: low bytes came first and sit in the top of rdata_q
  always_comb begin
    case (wb_ctrl_i.offset)
      2'b00:   rdata_w = rdata_i;
      2'b01:   rdata_w = {rdata_i[7:0], rdata_q[31:8]};
      2'b10:   rdata_w = {rdata_i[15:0], rdata_q[31:16]};
      default: rdata_w = {rdata_i[23:0], rdata_q[31:24]};
    endcase
  end

  always_comb begin
    case (wb_ctrl_i.offset)
      2'b00:   half_sel = rdata_i[15:0];
      2'b01:   half_sel = rdata_i[23:8];
      2'b10:   half_sel = rdata_i[31:16];
      default: half_sel = {rdata_i[7:0], rdata_q[31:24]}; // split half
    endcase
  end

  assign byte_sel = rdata_i[{wb_ctrl_i.offset, 3'b000} +: 8]; // never split

  ////////////////////
  // extension
  ////////////////////
  assign rdata_h = {{16{fill_bit(half_sel[15], wb_ctrl_i.ext)}}, half_sel};
  assign rdata_b = {{24{fill_bit(byte_sel[7], wb_ctrl_i.ext)}}, byte_sel};

  always_comb begin
    case (wb_ctrl_i.dtype)
      `LSU_TYPE_WORD: rdata_ext = rdata_w;
      `LSU_TYPE_HALF: rdata_ext = rdata_h;
      default:        rdata_ext = rdata_b; // byte, codes 2 and 3
    endcase
  end

  // raw word kept while the second half is still to come
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata_q <= '0;
    end else if (rvalid_i && !wb_ctrl_i.we) begin // stores leave it alone
      if (misaligned_phase_i || misaligned_i) begin
        rdata_q <= rdata_i;
      end else begin
        rdata_q <= rdata_ext;
      end
    end
  end

  // live on rvalid, held between responses
  assign rdata_o = rvalid_i ? rdata_ext : rdata_q;

endmodule

// File: logic/lsu_top.sv
/*
  load/store unit top
  decode, bus control and result path between the core's
  execute stage and a request/grant data bus
*/
`timescale 1ns/100ps

module lsu_top (
  input  logic              clk,
  input  logic              rst_n,

  // core side
  input  logic              req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  logic              misaligned_phase_i,
  output logic              misaligned_o,
  output logic              ready_ex_o,
  output logic              ready_wb_o,
  output logic              busy_o,
  output lsu_pkg::word_t    rdata_o,

  // data bus
  output logic              bus_req_o,
  output lsu_pkg::bus_req_t bus_o,
  input  logic              bus_gnt_i,
  input  logic              bus_rvalid_i,
  input  lsu_pkg::word_t    bus_rdata_i
);

  lsu_pkg::bus_req_t dec_bus;     // decoded address phase
  lsu_pkg::offset_t  dec_offset;  // byte offset of this access
  lsu_pkg::wb_ctrl_t wb_ctrl;     // control for the pending response

  ////////////////////
  // decode
  ////////////////////
  lsu_decode lsu_decode_inst (
    .req_i              (req_i),
    .req_valid_i        (req_valid_i),
    .misaligned_phase_i (misaligned_phase_i),
    .bus_o              (dec_bus),
    .offset_o           (dec_offset),
    .misaligned_o       (misaligned_o)
  );

  ////////////////////
  // bus control
  ////////////////////
  lsu_execute lsu_execute_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .offset_i     (dec_offset),
    .bus_i        (dec_bus),
    .bus_req_o    (bus_req_o),
    .bus_o        (bus_o),
    .bus_gnt_i    (bus_gnt_i),
    .bus_rvalid_i (bus_rvalid_i),
    .ready_ex_o   (ready_ex_o),
    .ready_wb_o   (ready_wb_o),
    .busy_o       (busy_o),
    .wb_ctrl_o    (wb_ctrl)
  );

  ////////////////////
  // load result
  ////////////////////
  lsu_result lsu_result_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .wb_ctrl_i          (wb_ctrl),
    .rvalid_i           (bus_rvalid_i),
    .rdata_i            (bus_rdata_i),
    .misaligned_phase_i (misaligned_phase_i),
    .misaligned_i       (misaligned_o),
    .rdata_o            (rdata_o)
  );

endmodule

// File: test/tb_clock_gen.sv
/*
  testbench clock and reset
  free running clock, active low reset held for a few cycles
*/
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 10,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // release away from the active edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

// File: test/tb_mem_model.sv
/*
  data memory model
  word addressed, random grant, answers each accepted transfer
  with one in-order rvalid after a random delay
*/
`timescale 1ns/100ps

module tb_mem_model #(
  parameter int          WORDS = 16,
  parameter logic [31:0] SEED  = 32'hb087
) (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req_i,
  input  lsu_pkg::bus_req_t bus_i,
  output logic              gnt_o,
  output logic              rvalid_o,
  output lsu_pkg::word_t    rdata_o
);

  localparam int AW = $clog2(WORDS);

  lsu_pkg::word_t mem [WORDS];
  lsu_pkg::word_t resp_data [$]; // read data captured at acceptance
  int             resp_due [$];  // earliest cycle for each response
  int             cycle;
  int             idx;
  integer         seed;

  initial begin
    seed     = SEED;
    cycle    = 0;
    gnt_o    = 1'b0;
    rvalid_o = 1'b0;
    rdata_o  = '0;
    for (int i = 0; i < WORDS; i++) begin
      mem[i] = (32'h9e3779b9 * (i + 1)) ^ (i << 20); // differs per word
    end
  end

  ////////////////////
  // address phase
  ////////////////////
  always @(posedge clk) begin
    cycle = cycle + 1;
    if (rst_n && req_i && gnt_o) begin
      idx = int'(bus_i.addr[AW+1:2]); // wraps at the top of memory
      if (bus_i.we) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (bus_i.be[lane]) mem[idx][8*lane +: 8] = bus_i.wdata[8*lane +: 8];
        end
      end
      resp_data.push_back(mem[idx]);
      resp_due.push_back(cycle + ($random(seed) & 3)); // 0..3 extra cycles
    end
  end

  ////////////////////
  // response phase, driven off the falling edge
  ////////////////////
  always @(negedge clk) begin
    if (!rst_n) begin
      gnt_o    <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      gnt_o <= (($random(seed) & 3) != 0); // grant three times in four
      if (resp_due.size() > 0 && cycle >= resp_due[0]) begin
        rvalid_o <= 1'b1;
        rdata_o  <= resp_data.pop_front();
        void'(resp_due.pop_front());
      end else begin
        rvalid_o <= 1'b0;
      end
    end
  end

endmodule

// File: test/tb_lsu.sv
/*
  load/store unit testbench
  random loads and stores against a byte model of memory,
  checks bus phases, split accesses, load data and busy
*/
`timescale 1ns/100ps
`include "lsu_defs.svh"

module tb_lsu;

  localparam int N_ACCESS = 300;
  localparam int LIMIT    = 40 * N_ACCESS; // cycle budget

  logic              clk;
  logic              rst_n;
  logic              req_valid;
  logic              misaligned_phase;
  logic              misaligned;
  logic              ready_ex;
  logic              ready_wb;
  logic              busy;
  logic              bus_req;
  logic              bus_gnt;
  logic              bus_rvalid;
  lsu_pkg::lsu_req_t req;
  lsu_pkg::word_t    rdata;
  lsu_pkg::word_t    bus_rdata;
  lsu_pkg::bus_req_t bus;

  logic [7:0]        mem_b [64];  // reference memory in bytes
  bit                exp_chk [$]; // one entry per bus transfer
  lsu_pkg::word_t    exp_val [$];
  lsu_pkg::bus_req_t exp_bus;     // address phase the driver expects
  lsu_pkg::bus_req_t prev_bus;
  logic              exp_mis;
  logic              prev_wait;   // request seen without grant
  bit                pop_chk;
  lsu_pkg::word_t    pop_val;
  integer            seed;
  int                errors;
  int                checks;
  int                cycles;
  int                outstanding;

  tb_clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(2)) tb_clock_gen_inst (
    .clk   (clk),
    .rst_n (rst_n)
  );

  tb_mem_model #(.WORDS(16), .SEED(32'hb087)) tb_mem_model_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_i    (bus_req),
    .bus_i    (bus),
    .gnt_o    (bus_gnt),
    .rvalid_o (bus_rvalid),
    .rdata_o  (bus_rdata)
  );

  lsu_top lsu_top_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .req_valid_i        (req_valid),
    .req_i              (req),
    .misaligned_phase_i (misaligned_phase),
    .misaligned_o       (misaligned),
    .ready_ex_o         (ready_ex),
    .ready_wb_o         (ready_wb),
    .busy_o             (busy),
    .rdata_o            (rdata),
    .bus_req_o          (bus_req),
    .bus_o              (bus),
    .bus_gnt_i          (bus_gnt),
    .bus_rvalid_i       (bus_rvalid),
    .bus_rdata_i        (bus_rdata)
  );

  ////////////////////
  // checks
  ////////////////////
  task automatic check_val(input string name, input logic [31:0] exp_v,
                           input logic [31:0] act_v);
    checks++;
    assert (exp_v === act_v) else begin
      errors++;
      $display("error %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_cond(input string what, input logic ok);
    checks++;
    assert (ok === 1'b1) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  ////////////////////
  // reference rules
  ////////////////////
  function automatic int size_of(input lsu_pkg::dtype_t dt);
    if (dt == `LSU_TYPE_WORD) return 4;
    if (dt == `LSU_TYPE_HALF) return 2;
    return 1; // codes 2 and 3
  endfunction

  // lanes from the offset upward and from lane 0 in phase two
  function automatic lsu_pkg::be_t be_for(input int off, input int n, input bit phase2);
    lsu_pkg::be_t be;
    for (int l = 0; l < 4; l++) begin
      be[l] = phase2 ? (l < off + n - 4) : (l >= off && l < off + n);
    end
    return be;
  endfunction

  function automatic lsu_pkg::word_t rotl(input lsu_pkg::word_t w, input int off);
    logic [63:0] both;
    both = {w, w} << (8 * off);
    return both[63:32];
  endfunction

  function automatic lsu_pkg::word_t load_value(input lsu_pkg::word_t addr, input int n,
                                                 input lsu_pkg::ext_t ext);
    lsu_pkg::word_t v;
    logic           fill;
    v = '0;
    for (int k = 0; k < n; k++) v[8*k +: 8] = mem_b[(addr[5:0] + k) % 64];
    if (n == 4) return v;
    if (ext == `LSU_EXT_ZERO) fill = 1'b0;
    else if (ext == `LSU_EXT_ONE) fill = 1'b1;
    else fill = v[8*n-1]; // sign for codes 1 and 3
    for (int b = 8 * n; b < 32; b++) v[b] = fill;
    return v;
  endfunction

  // hold one phase until execute takes it
  task automatic issue(input lsu_pkg::lsu_req_t r, input logic phase2, input logic mis);
    req              = r;
    misaligned_phase = phase2;
    exp_mis          = mis;
    req_valid        = 1'b1;
    do begin
      @(posedge clk);
      check_val("misaligned", 32'(exp_mis), 32'(misaligned));
    end while (!ready_ex);
    @(negedge clk);
    req_valid = 1'b0;
  endtask

  ////////////////////
  // bus monitor
  ////////////////////
  always @(posedge clk) begin
    if (rst_n) begin
      if (prev_wait) begin
        check_cond("bus request dropped before its grant", bus_req);
        check_cond("bus address phase changed before its grant", bus == prev_bus);
      end
      if (outstanding > 0) check_cond("busy low with a transfer unanswered", busy);
      if (bus_req && bus_gnt) begin
        check_val("bus addr", exp_bus.addr, bus.addr);
        check_val("bus we", 32'(exp_bus.we), 32'(bus.we));
        check_val("bus be", 32'(exp_bus.be), 32'(bus.be));
        check_val("bus wdata", exp_bus.wdata, bus.wdata);
      end
      if (bus_rvalid) begin
        if (exp_chk.size() == 0) begin
          check_cond("rvalid arrived with no transfer outstanding", 1'b0);
        end else begin
          pop_chk = exp_chk.pop_front();
          pop_val = exp_val.pop_front();
          if (pop_chk) check_val("load data", pop_val, rdata);
        end
      end
      outstanding = outstanding + int'(bus_req && bus_gnt) - int'(bus_rvalid);
      check_cond("more than two transfers outstanding", outstanding <= 2);
      prev_wait = bus_req && !bus_gnt;
      prev_bus  = bus;
    end
  end

  // hang guard
  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: run exceeded %0d cycles", LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////
  // core model
  ////////////////////
  initial begin
    lsu_pkg::lsu_req_t r;
    lsu_pkg::word_t    addr;
    lsu_pkg::word_t    a2;
    int                n;
    int                off;
    logic              mis;
    seed             = 32'hb087;
    errors           = 0;
    checks           = 0;
    cycles           = 0;
    outstanding      = 0;
    prev_wait        = 1'b0;
    req_valid        = 1'b0;
    req              = '0;
    misaligned_phase = 1'b0;
    exp_mis          = 1'b0;
    exp_bus          = '0;
    @(posedge rst_n);
    @(negedge clk);
    for (int i = 0; i < 16; i++) begin
      for (int k = 0; k < 4; k++) mem_b[4*i + k] = tb_mem_model_inst.mem[i][8*k +: 8];
    end
    // idle state straight out of reset
    check_val("reset busy", 32'd0, 32'(busy));
    check_val("reset ready_wb", 32'd1, 32'(ready_wb));
    check_val("reset misaligned", 32'd0, 32'(misaligned));
    check_val("reset bus_req", 32'd0, 32'(bus_req));
    check_val("reset rdata", 32'd0, rdata);

    for (int i = 0; i < N_ACCESS; i++) begin
      r            = '0;
      r.we         = 1'($random(seed));
      r.dtype      = 2'($random(seed)); // all four codes
      r.ext        = 2'($random(seed));
      r.wdata      = $random(seed);
      r.operand_a  = $random(seed);
      r.operand_b  = $random(seed);
      r.use_incr   = 1'($random(seed));
      addr = r.use_incr ? r.operand_a + r.operand_b : r.operand_a;
      n    = size_of(r.dtype);
      off  = int'(addr[1:0]);
      mis  = (n == 4 && off != 0) || (n == 2 && off == 3);
      if (r.we) begin
        for (int k = 0; k < n; k++) mem_b[(addr[5:0] + k) % 64] = r.wdata[8*k +: 8];
        exp_chk.push_back(1'b0);
        exp_val.push_back('0);
      end else begin
        exp_chk.push_back(!mis); // first half of a split load is not checked
        exp_val.push_back(load_value(addr, n, r.ext));
      end
      if (mis) begin
        exp_chk.push_back(!r.we);
        exp_val.push_back(r.we ? '0 : load_value(addr, n, r.ext));
      end
      exp_bus.addr  = addr;
      exp_bus.we    = r.we;
      exp_bus.be    = be_for(off, n, 1'b0);
      exp_bus.wdata = rotl(r.wdata, off);
      issue(r, 1'b0, mis);
      if (mis) begin
        a2          = addr + 32'd4; // core steps to the next word
        r.operand_a = a2;
        r.use_incr  = 1'b0;
        exp_bus.addr = {a2[31:2], 2'b00};
        exp_bus.be   = be_for(off, n, 1'b1);
        issue(r, 1'b1, 1'b0);
      end
      misaligned_phase = 1'b0;
      repeat ($random(seed) & 1) @(negedge clk); // occasional idle cycle
    end

    while (exp_chk.size() != 0) @(posedge clk);
    @(negedge clk);
    check_val("drained outstanding", 32'd0, 32'(outstanding));
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: sources.f
+incdir+logic
logic/lsu_pkg.sv
logic/lsu_decode.sv
logic/lsu_execute.sv
logic/lsu_result.sv
logic/lsu_top.sv
test/tb_clock_gen.sv
test/tb_mem_model.sv
test/tb_lsu.sv

// File: Makefile
# Verilator build and run for the load/store unit testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary -j 0
TOP       ?= tb_lsu
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= sources.f

SRCS := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS := $(wildcard logic/*.svh)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

# rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation failed"; exit 1; fi

check: run
	@grep -q "TESTBENCH PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
